/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_zx_mem_pager
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
source/zx_bus_pkg.sv
source/zx_mem_pkg.sv
source/pipe_stage.sv
source/pager_regs.sv
source/window_mapper.sv
source/zx_mem_pager.sv
tests/zx_mem_pager_chk.sv
tests/tb_zx_mem_pager.sv

/* source/pager_regs.sv */
`timescale 1ns/10ps

module pager_regs (
	input  logic                                            fclk,
	input  logic                                            reset,

	// io channel from cpu
	input  logic                                            io_valid,
	output logic                                            io_ready,
	input  logic                                            io_write,
	input  zx_bus_pkg::zaddr_t                              io_addr,
	input  zx_bus_pkg::zdata_t                              io_wdata,

	// readback responses
	output logic                                            rsp_valid,
	input  logic                                            rsp_ready,
	output zx_bus_pkg::zdata_t                              rsp_data,

	input  logic                                            dos,

	output zx_mem_pkg::page_t [zx_mem_pkg::NUM_WINDOWS-1:0] win_page,
	output logic [zx_mem_pkg::NUM_WINDOWS-1:0]              win_romnram
);

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	logic [WIN_BITS-1:0] sel;
	logic [7:0]          port_lo;
	logic                io_fire;
	logic                rsp_push_ready;
	rsp_payload_t        rsp_in;
	rsp_payload_t        rsp_out;

	assign sel     = io_addr[15 -: WIN_BITS];
	assign port_lo = io_addr[7:0];

	// writes wait on the response slice too, so io order is kept
	assign io_ready = rsp_push_ready;
	assign io_fire  = io_valid && io_ready;

	//////////////////////////////
	// window registers
	//////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			win_page    <= RESET_PAGES;
			win_romnram <= RESET_ROMNRAM;
		end
		else if (io_fire && io_write)
		begin
			if (port_lo == PORT_RAM_PAGE)
			begin
				win_page[sel]    <= io_wdata;
				win_romnram[sel] <= 1'b0;
			end
			else if (port_lo == PORT_ROM_PAGE)
			begin
				win_page[sel]    <= io_wdata;
				win_romnram[sel] <= 1'b1;
			end
		end
	end

	//////////////////////////////
	// readback
	//////////////////////////////

	always_comb
	begin
		rsp_in.data = FLOAT_BUS;
		if (port_lo == PORT_READBACK)
		begin
			// a8 picks flags over page
			if (io_addr[8])
				rsp_in.data = {6'd0, dos, win_romnram[sel]};
			else
				rsp_in.data = win_page[sel];
		end
	end

	pipe_stage #(
		.payload_t(rsp_payload_t)
	) rsp_stage (
		.fclk     (fclk),
		.reset    (reset),
		.in_valid (io_valid && !io_write),
		.in_ready (rsp_push_ready),
		.in_data  (rsp_in),
		.out_valid(rsp_valid),
		.out_ready(rsp_ready),
		.out_data (rsp_out)
	);

	assign rsp_data = rsp_out.data;

endmodule

/* source/pipe_stage.sv */
`timescale 1ns/10ps

module pipe_stage #(
	parameter type payload_t = logic [7:0]
)(
	input  logic     fclk,
	input  logic     reset,

	input  logic     in_valid,
	output logic     in_ready,
	input  payload_t in_data,

	output logic     out_valid,
	input  logic     out_ready,
	output payload_t out_data
);

	// two entries, used as a tiny ring
	payload_t entry [2];

	logic [1:0] count;
	logic [1:0] count_next;
	logic       wr_ptr;
	logic       rd_ptr;
	logic       push;
	logic       pop;

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_comb
	begin
		count_next = count + {1'b0, push} - {1'b0, pop};
	end

	// control state
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			count    <= 2'd0;
			wr_ptr   <= 1'b0;
			rd_ptr   <= 1'b0;
			in_ready <= 1'b1;
		end
		else
		begin
			count <= count_next;
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// registered ready, low only when both entries hold data
			in_ready <= (count_next != 2'd2);
		end
	end

	always_ff @(posedge fclk)
	begin
		if (push)
			entry[wr_ptr] <= in_data;
	end

	assign out_valid = (count != 2'd0);
	assign out_data  = entry[rd_ptr];

endmodule

/* source/window_mapper.sv */
`timescale 1ns/10ps

module window_mapper (
	input  logic                                            fclk,
	input  logic                                            reset,

	// cpu memory channel
	input  logic                                            mem_valid,
	output logic                                            mem_ready,
	input  zx_bus_pkg::zaddr_t                              mem_addr,
	input  logic                                            mem_write,
	input  zx_bus_pkg::zdata_t                              mem_wdata,
	input  logic                                            mem_fetch,

	input  zx_mem_pkg::page_t [zx_mem_pkg::NUM_WINDOWS-1:0] win_page,
	input  logic [zx_mem_pkg::NUM_WINDOWS-1:0]              win_romnram,

	output logic                                            dos,

	// physical side toward memory
	output logic                                            phys_valid,
	input  logic                                            phys_ready,
	output zx_mem_pkg::paddr_t                              phys_addr,
	output logic                                            phys_rom,
	output logic                                            phys_write,
	output zx_bus_pkg::zdata_t                              phys_wdata
);

	import zx_mem_pkg::*;

	logic [WIN_BITS-1:0] win;
	logic                mem_fire;
	logic                trap_hit;
	page_t               eff_page;
	mem_payload_t        map_in;
	mem_payload_t        map_out;

	assign win      = mem_addr[15 -: WIN_BITS];
	assign mem_fire = mem_valid && mem_ready;

	//////////////////////////////
	// translation
	//////////////////////////////

	always_comb
	begin
		eff_page = win_page[win];
		// rom pages get dos in bit 0
		if (win_romnram[win])
			eff_page[0] = dos;

		map_in.addr  = {eff_page, mem_addr[OFFSET_BITS-1:0]};
		map_in.rom   = win_romnram[win];
		map_in.write = mem_write;
		map_in.wdata = mem_wdata;
	end

	//////////////////////////////
	// dos flag
	//////////////////////////////

	assign trap_hit = (mem_addr[15:8] == DOS_TRAP_HI) && win_romnram[0];

	always_ff @(posedge fclk)
	begin
		if (reset)
			dos <= 1'b0;
		else if (mem_fire && mem_fetch)
		begin
			if (trap_hit)
				dos <= 1'b1;
			else if (win != '0)
				dos <= 1'b0;   // leaving window 0 drops out of dos
		end
	end

	pipe_stage #(
		.payload_t(mem_payload_t)
	) map_stage (
		.fclk     (fclk),
		.reset    (reset),
		.in_valid (mem_valid),
		.in_ready (mem_ready),
		.in_data  (map_in),
		.out_valid(phys_valid),
		.out_ready(phys_ready),
		.out_data (map_out)
	);

	assign phys_addr  = map_out.addr;
	assign phys_rom   = map_out.rom;
	assign phys_write = map_out.write;
	assign phys_wdata = map_out.wdata;

endmodule

/* source/zx_bus_pkg.sv */
package zx_bus_pkg;

	//////////////////////////////
	// cpu side bus
	//////////////////////////////

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// port decode works on the low address byte only
	localparam logic [7:0] PORT_RAM_PAGE = 8'hF7;
	localparam logic [7:0] PORT_ROM_PAGE = 8'hF6;
	localparam logic [7:0] PORT_READBACK = 8'hBE;

	// floating bus value for unused ports
	localparam zdata_t FLOAT_BUS = 8'hFF;

endpackage

/* source/zx_mem_pager.sv */
`timescale 1ns/10ps

module zx_mem_pager (
	input  logic               fclk,
	input  logic               reset,

	// io channel
	input  logic               io_valid,
	output logic               io_ready,
	input  logic               io_write,
	input  zx_bus_pkg::zaddr_t io_addr,
	input  zx_bus_pkg::zdata_t io_wdata,

	// io read responses
	output logic               rsp_valid,
	input  logic               rsp_ready,
	output zx_bus_pkg::zdata_t rsp_data,

	// memory channel
	input  logic               mem_valid,
	output logic               mem_ready,
	input  zx_bus_pkg::zaddr_t mem_addr,
	input  logic               mem_write,
	input  zx_bus_pkg::zdata_t mem_wdata,
	input  logic               mem_fetch,

	// translated accesses
	output logic               phys_valid,
	input  logic               phys_ready,
	output zx_mem_pkg::paddr_t phys_addr,
	output logic               phys_rom,
	output logic               phys_write,
	output zx_bus_pkg::zdata_t phys_wdata
);

	import zx_mem_pkg::*;

	page_t [NUM_WINDOWS-1:0] win_page;
	logic [NUM_WINDOWS-1:0]  win_romnram;
	logic                    dos;

	//////////////////////////////
	// port registers
	//////////////////////////////

	pager_regs pager_regs (
		.fclk       (fclk),
		.reset      (reset),
		.io_valid   (io_valid),
		.io_ready   (io_ready),
		.io_write   (io_write),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_data   (rsp_data),
		.dos        (dos),
		.win_page   (win_page),
		.win_romnram(win_romnram)
	);

	//////////////////////////////
	// address mapper
	//////////////////////////////

	window_mapper window_mapper (
		.fclk       (fclk),
		.reset      (reset),
		.mem_valid  (mem_valid),
		.mem_ready  (mem_ready),
		.mem_addr   (mem_addr),
		.mem_write  (mem_write),
		.mem_wdata  (mem_wdata),
		.mem_fetch  (mem_fetch),
		.win_page   (win_page),
		.win_romnram(win_romnram),
		.dos        (dos),
		.phys_valid (phys_valid),
		.phys_ready (phys_ready),
		.phys_addr  (phys_addr),
		.phys_rom   (phys_rom),
		.phys_write (phys_write),
		.phys_wdata (phys_wdata)
	);

endmodule

/* source/zx_mem_pkg.sv */
package zx_mem_pkg;

	//////////////////////////////
	// memory map
	//////////////////////////////

	localparam int NUM_WINDOWS = 4;
	localparam int WIN_BITS    = 2;
	localparam int OFFSET_BITS = 14;

	typedef logic [7:0] page_t;

	// page on top, 16 KB offset below
	typedef logic [$bits(page_t)+OFFSET_BITS-1:0] paddr_t;

	// window 3 leftmost
	localparam page_t [NUM_WINDOWS-1:0] RESET_PAGES = {8'h00, 8'h02, 8'h05, 8'h00};

	// only window 0 starts in rom
	localparam logic [NUM_WINDOWS-1:0] RESET_ROMNRAM = 4'b0001;

	// trap range is 0x3D00..0x3DFF
	localparam logic [7:0] DOS_TRAP_HI = 8'h3D;

	//////////////////////////////
	// slice payloads
	//////////////////////////////

	typedef struct packed {
		paddr_t             addr;
		logic               rom;
		logic               write;
		zx_bus_pkg::zdata_t wdata;
	} mem_payload_t;

	typedef struct packed {
		zx_bus_pkg::zdata_t data;
	} rsp_payload_t;

endpackage

/* tests/tb_zx_mem_pager.sv */
`timescale 1ns/10ps

module tb_zx_mem_pager;

	import zx_bus_pkg::*;
	import zx_mem_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int N_WRITE      = 40;
	localparam int N_MEM        = 200;
	localparam int N_PORT       = 30;
	// all io and memory transactions of the five tests
	localparam int N_TXN        = 8 + 3 * N_WRITE + N_MEM + 11 + 2 * N_PORT + 8;
	localparam int MAX_CYCLES   = 8 * N_TXN + RESET_CYCLES;

	logic               fclk;
	logic               reset;
	logic               io_valid, io_ready, io_write;
	zaddr_t             io_addr;
	zdata_t             io_wdata;
	logic               rsp_valid, rsp_ready;
	zdata_t             rsp_data;
	logic               mem_valid, mem_ready, mem_write, mem_fetch;
	zaddr_t             mem_addr;
	zdata_t             mem_wdata;
	logic               phys_valid, phys_ready, phys_rom, phys_write;
	paddr_t             phys_addr;
	zdata_t             phys_wdata;

	// reference model state
	page_t              m_page [NUM_WINDOWS];
	logic               m_rom [NUM_WINDOWS];
	logic               m_dos;
	zdata_t             rsp_q [$];
	mem_payload_t       phys_q [$];

	string              test_name;
	int                 errors = 0;
	int                 test_start = 0;
	int                 tests_run = 0;
	int                 tests_failed = 0;
	int                 cycles = 0;

	zx_mem_pager i_zx_mem_pager (.*);

	initial
		fclk = 1'b0;
	always #4 fclk = ~fclk;

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic zaddr_t rand16();
		logic [31:0] r;
		r = $urandom;
		return r[15:0];
	endfunction

	function automatic zdata_t rand8();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	// random address inside one window
	function automatic zaddr_t win_addr(input logic [1:0] w);
		zaddr_t a;
		a        = rand16();
		a[15:14] = w;
		return a;
	endfunction

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: %s expected %b actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_rsp(input zdata_t exp, input zdata_t act);
		if (act !== exp)
		begin
			$display("[ERROR] %s: rsp expected %h actual %h", test_name, exp, act);
			errors++;
		end
	endtask

	task automatic check_phys(input mem_payload_t exp, input mem_payload_t act);
		if (act !== exp)
		begin
			$display({"[ERROR] %s: phys expected addr %h rom %b wr %b data %h",
				" actual addr %h rom %b wr %b data %h"}, test_name,
				exp.addr, exp.rom, exp.write, exp.wdata,
				act.addr, act.rom, act.write, act.wdata);
			errors++;
		end
	endtask

	// starts and ends on a falling edge
	task automatic io_txn(input logic wr, input zaddr_t addr, input zdata_t data);
		logic [1:0] w;
		w        = addr[15:14];
		io_valid = 1'b1;
		io_write = wr;
		io_addr  = addr;
		io_wdata = data;
		while (!io_ready)
			@(negedge fclk);
		// accepted on the coming edge
		if (wr)
		begin
			if (addr[7:0] == 8'hF7 || addr[7:0] == 8'hF6)
			begin
				m_page[w] = data;
				m_rom[w]  = (addr[7:0] == 8'hF6);
			end
		end
		else if (addr[7:0] != 8'hBE)
			rsp_q.push_back(8'hFF);
		else if (addr[8])
			rsp_q.push_back({6'd0, m_dos, m_rom[w]});
		else
			rsp_q.push_back(m_page[w]);
		@(negedge fclk);
		io_valid = 1'b0;
	endtask

	task automatic mem_txn(input zaddr_t addr, input logic wr, input zdata_t data,
		input logic fetch);
		logic [1:0]   w;
		page_t        pg;
		mem_payload_t exp;
		w         = addr[15:14];
		mem_valid = 1'b1;
		mem_addr  = addr;
		mem_write = wr;
		mem_wdata = data;
		mem_fetch = fetch;
		while (!mem_ready)
			@(negedge fclk);
		pg = m_page[w];
		if (m_rom[w])
			pg[0] = m_dos;
		exp.addr  = {pg, addr[13:0]};
		exp.rom   = m_rom[w];
		exp.write = wr;
		exp.wdata = data;
		phys_q.push_back(exp);
		// translation above used dos from before this fetch
		if (fetch && addr[15:8] == 8'h3D && m_rom[0])
			m_dos = 1'b1;
		else if (fetch && w != 2'd0)
			m_dos = 1'b0;
		@(negedge fclk);
		mem_valid = 1'b0;
	endtask

	task automatic readback_all();
		zaddr_t a;
		for (int w = 0; w < NUM_WINDOWS; w++)
		begin
			a        = 16'h00BE;
			a[15:14] = w[1:0];
			io_txn(1'b0, a, 8'h00);
			a[8] = 1'b1;
			io_txn(1'b0, a, 8'h00);
		end
	endtask

	task automatic start_test(input string name);
		test_name  = name;
		test_start = errors;
	endtask

	task automatic end_test();
		while (rsp_q.size() != 0 || phys_q.size() != 0)
			@(negedge fclk);
		tests_run++;
		if (errors != test_start)
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - test_start);
		end
		else
			$display("%s: passed", test_name);
	endtask

	task automatic finish_run();
		int asserts;
		asserts = i_zx_mem_pager.pager_regs.rsp_stage.slice_chk.fail_count
			+ i_zx_mem_pager.window_mapper.map_stage.slice_chk.fail_count;
		errors += asserts;
		$display("tests run %0d, tests failed %0d, assertion failures %0d, errors %0d",
			tests_run, tests_failed, asserts, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	endtask

	//////////////////////////////
	// output monitors
	//////////////////////////////

	// ready is drawn before the transfer is judged
	always @(negedge fclk)
	begin
		rsp_ready = ($urandom_range(3) != 0);
		if (rsp_valid && rsp_ready)
		begin
			if (rsp_q.size() == 0)
			begin
				$display("%s: response seen with no read pending", test_name);
				errors++;
			end
			else
				check_rsp(rsp_q.pop_front(), rsp_data);
		end
	end

	always @(negedge fclk)
	begin
		phys_ready = ($urandom_range(3) != 0);
		if (phys_valid && phys_ready)
		begin
			if (phys_q.size() == 0)
			begin
				$display("%s: memory access seen with none pending", test_name);
				errors++;
			end
			else
				check_phys(phys_q.pop_front(),
					mem_payload_t'({phys_addr, phys_rom, phys_write, phys_wdata}));
		end
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("run stopped after %0d cycles with transactions still open", cycles);
			errors++;
			finish_run();
		end
	end

	//////////////////////////////
	// tests
	//////////////////////////////

	initial
	begin
		zaddr_t a;
		void'($urandom(61));
		reset      = 1'b1;
		io_valid   = 1'b0;
		io_write   = 1'b0;
		io_addr    = '0;
		io_wdata   = '0;
		rsp_ready  = 1'b1;
		mem_valid  = 1'b0;
		mem_addr   = '0;
		mem_write  = 1'b0;
		mem_wdata  = '0;
		mem_fetch  = 1'b0;
		phys_ready = 1'b1;
		m_page     = '{8'h00, 8'h05, 8'h02, 8'h00};
		m_rom      = '{1'b1, 1'b0, 1'b0, 1'b0};
		m_dos      = 1'b0;
		repeat (RESET_CYCLES) @(negedge fclk);
		reset = 1'b0;

		start_test("reset_readback");
		check_flag("rsp_valid", 1'b0, rsp_valid);
		check_flag("phys_valid", 1'b0, phys_valid);
		check_flag("io_ready", 1'b1, io_ready);
		check_flag("mem_ready", 1'b1, mem_ready);
		readback_all();
		end_test();

		start_test("page_writes");
		repeat (N_WRITE)
		begin
			a       = rand16();
			a[7:0]  = ($urandom_range(1) != 0) ? 8'hF6 : 8'hF7;
			io_txn(1'b1, a, rand8());
			a[7:0]  = 8'hBE;
			a[8]    = 1'b0;
			io_txn(1'b0, a, 8'h00);
			a[8]    = 1'b1;
			io_txn(1'b0, a, 8'h00);
		end
		end_test();

		start_test("mem_random");
		repeat (N_MEM)
		begin
			if ($urandom_range(1) != 0)
				mem_txn(rand16(), 1'b0, 8'h00, 1'b1);
			else
				mem_txn(rand16(), ($urandom_range(1) != 0), rand8(), 1'b0);
		end
		end_test();

		// page bit 0 differs from the dos value expected in each window
		start_test("dos_trap");
		io_txn(1'b1, 16'h00F6, rand8() & 8'hFE);
		io_txn(1'b1, 16'hC0F6, rand8() | 8'h01);
		mem_txn(win_addr(2'd1), 1'b0, 8'h00, 1'b1);
		mem_txn({8'h3D, rand8()}, 1'b0, 8'h00, 1'b1);
		io_txn(1'b0, 16'h01BE, 8'h00);
		mem_txn(win_addr(2'd0), 1'b0, 8'h00, 1'b0);
		mem_txn(win_addr(2'd3), 1'b0, 8'h00, 1'b0);
		mem_txn(win_addr(2'd3), 1'b0, 8'h00, 1'b1);
		io_txn(1'b0, 16'h01BE, 8'h00);
		mem_txn(win_addr(2'd0), 1'b0, 8'h00, 1'b0);
		mem_txn(win_addr(2'd3), 1'b0, 8'h00, 1'b0);
		end_test();

		start_test("float_ports");
		repeat (N_PORT)
		begin
			a = rand16();
			if (a[7:0] inside {8'hF7, 8'hF6, 8'hBE})
				a[7:0] = 8'h00;
			io_txn(1'b0, a, 8'h00);
			a = rand16();
			if (a[7:0] inside {8'hF7, 8'hF6, 8'hBE})
				a[7:0] = 8'h01;
			io_txn(1'b1, a, rand8());
		end
		readback_all();
		end_test();

		finish_run();
	end

endmodule

/* tests/zx_mem_pager_chk.sv */
`timescale 1ns/10ps

module zx_mem_pager_chk #(
	parameter type payload_t = logic [7:0]
)(
	input logic     fclk,
	input logic     reset,
	input logic     in_valid,
	input logic     in_ready,
	input logic     out_valid,
	input logic     out_ready,
	input payload_t out_data
);

	int         fail_count = 0;
	logic [1:0] held;

	// occupancy rebuilt from the two handshakes
	always_ff @(posedge fclk)
	begin
		if (reset)
			held <= 2'd0;
		else
			held <= held + {1'b0, in_valid && in_ready} - {1'b0, out_valid && out_ready};
	end

	// stalled output keeps valid and data
	hold_on_stall: assert property (@(posedge fclk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
	else
	begin
		fail_count++;
		$error("stalled slice output dropped valid or changed data");
	end

	valid_needs_entry: assert property (@(posedge fclk) disable iff (reset)
		out_valid |-> held != 2'd0)
	else
	begin
		fail_count++;
		$error("slice output valid with no entry held");
	end

	known_handshake: assert property (@(posedge fclk) disable iff (reset)
		!$isunknown({out_valid, in_ready}))
	else
	begin
		fail_count++;
		$error("slice valid or ready is unknown after reset");
	end

	known_data: assert property (@(posedge fclk) disable iff (reset)
		out_valid |-> !$isunknown(out_data))
	else
	begin
		fail_count++;
		$error("slice output data is unknown while valid");
	end

endmodule

// bound into the response slice and the mapper slice
bind pipe_stage zx_mem_pager_chk #(
	.payload_t(payload_t)
) slice_chk (
	.fclk     (fclk),
	.reset    (reset),
	.in_valid (in_valid),
	.in_ready (in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_data (out_data)
);
